// File: Bender.yml
package:
  name: catch_score

sources:
  - files:
      - score_pkg.sv
      - target_ledger.sv
      - score_tally.sv
      - score_digits.sv
      - catch_score_top.sv
  - target: test
    files:
      - tb_catch_score.sv

// File: catch_score_top.sv
module catch_score_top (
	input  logic                  Clk,
	input  logic                  reset,
	input  score_pkg::catch_vec_t catch_right,
	input  score_pkg::catch_vec_t catch_left,
	input  logic                  new_round,
	input  logic                  two_player,
	input  logic                  time_end,
	input  score_pkg::score_t     target_score,
	output score_pkg::digits_t    total_digits,
	output score_pkg::digits_t    left_digits,
	output score_pkg::digits_t    right_digits,
	output logic                  show_fail
);

	logic              hit_right;
	logic              hit_left;
	logic              grant_right;
	logic              grant_left;
	score_pkg::score_t points_right;
	score_pkg::score_t points_left;
	score_pkg::score_t score_right;
	score_pkg::score_t score_left;
	score_pkg::score_t score_total;

	//////////////////////////////
	// per-side ledgers
	//////////////////////////////

	target_ledger ledger_right (
		.Clk     (Clk),
		.reset   (reset),
		.clear   (new_round),
		.catches (catch_right),
		.grant   (grant_right),
		.hit     (hit_right),
		.points  (points_right)
	);

	target_ledger ledger_left (
		.Clk     (Clk),
		.reset   (reset),
		.clear   (new_round),
		.catches (catch_left),
		.grant   (grant_left),
		.hit     (hit_left),
		.points  (points_left)
	);

	//////////////////////////////
	// scoring
	//////////////////////////////

	score_tally tally (
		.Clk          (Clk),
		.reset        (reset),
		.new_round    (new_round),
		.two_player   (two_player),
		.time_end     (time_end),
		.target_score (target_score),
		.hit_right    (hit_right),
		.points_right (points_right),
		.hit_left     (hit_left),
		.points_left  (points_left),
		.grant_right  (grant_right),
		.grant_left   (grant_left),
		.score_right  (score_right),
		.score_left   (score_left),
		.score_total  (score_total),
		.show_fail    (show_fail)
	);

	//////////////////////////////
	// decimal display
	//////////////////////////////

	score_digits digits_total (
		.Clk    (Clk),
		.reset  (reset),
		.score  (score_total),
		.digits (total_digits)
	);

	score_digits digits_left (
		.Clk    (Clk),
		.reset  (reset),
		.score  (score_left),
		.digits (left_digits)
	);

	score_digits digits_right (
		.Clk    (Clk),
		.reset  (reset),
		.score  (score_right),
		.digits (right_digits)
	);

endmodule

// File: compile.f
score_pkg.sv
target_ledger.sv
score_tally.sv
score_digits.sv
catch_score_top.sv
tb_catch_score.sv

// File: score_digits.sv
module score_digits (
	input  logic               Clk,
	input  logic               reset,
	input  score_pkg::score_t  score,
	output score_pkg::digits_t digits
);

	// score divided by 1, 10, 100, 1000 and 10000
	score_pkg::score_t quot [score_pkg::NUM_DIGITS];

	// per-digit remainder before truncation
	score_pkg::score_t rem [score_pkg::NUM_DIGITS];

	score_pkg::digits_t next_digits;

	//////////////////////////////
	// stage one
	//////////////////////////////

	always_ff @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < score_pkg::NUM_DIGITS; i++) begin
				quot[i] <= '0;
			end
		end else begin
			for (int i = 0; i < score_pkg::NUM_DIGITS; i++) begin
				quot[i] <= score / score_pkg::score_t'(10 ** i);
			end
		end
	end

	//////////////////////////////
	// stage two
	//////////////////////////////

	// each digit is the gap between adjacent quotients
	always_comb begin
		for (int i = 0; i < score_pkg::NUM_DIGITS - 1; i++) begin
			rem[i] = quot[i] - score_pkg::score_t'(10) * quot[i+1];
		end
		// top digit wraps so the display is modulo 100000
		rem[score_pkg::NUM_DIGITS-1] = quot[score_pkg::NUM_DIGITS-1] % score_pkg::score_t'(10);
	end

	always_comb begin
		for (int i = 0; i < score_pkg::NUM_DIGITS; i++) begin
			next_digits[i] = rem[i][score_pkg::DIGIT_W-1:0];
		end
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			digits <= '0;
		end else begin
			digits <= next_digits;
		end
	end

endmodule

// File: score_pkg.sv
package score_pkg;

	//////////////////////////////
	// widths and counts
	//////////////////////////////

	localparam int SCORE_W      = 20;
	localparam int NUM_TARGETS  = 14;
	localparam int NUM_DIGITS   = 5;
	localparam int DIGIT_W      = 4;
	localparam int TARGET_IDX_W = 4;

	//////////////////////////////
	// shared types
	//////////////////////////////

	typedef logic [SCORE_W-1:0] score_t;

	// bit i stands for target i+1
	typedef logic [NUM_TARGETS-1:0] catch_vec_t;

	typedef logic [DIGIT_W-1:0] digit_t;

	// index 0 is the ones digit
	typedef digit_t [NUM_DIGITS-1:0] digits_t;

	//////////////////////////////
	// point table
	//////////////////////////////

	// entry 0 is target 1
	localparam score_t TARGET_POINTS [NUM_TARGETS] = '{
		20'd500,
		20'd500,
		20'd250,
		20'd250,
		20'd100,
		20'd100,
		20'd50,
		20'd50,
		20'd600,
		20'd20,
		20'd50,
		20'd50,
		20'd20,
		20'd20
	};

endpackage

// File: score_tally.sv
module score_tally (
	input  logic              Clk,
	input  logic              reset,
	input  logic              new_round,
	input  logic              two_player,
	input  logic              time_end,
	input  score_pkg::score_t target_score,
	input  logic              hit_right,
	input  score_pkg::score_t points_right,
	input  logic              hit_left,
	input  score_pkg::score_t points_left,
	output logic              grant_right,
	output logic              grant_left,
	output score_pkg::score_t score_right,
	output score_pkg::score_t score_left,
	output score_pkg::score_t score_total,
	output logic              show_fail
);

	// points of whichever side won this cycle
	score_pkg::score_t add_points;

	logic any_grant;

	// sums wrap at 2^20
	score_pkg::score_t next_total;
	score_pkg::score_t next_right;
	score_pkg::score_t next_left;

	//////////////////////////////
	// arbitration
	//////////////////////////////

	// right side always first
	// left waits while its catch is held
	assign grant_right = hit_right;
	assign grant_left  = hit_left && !hit_right;

	assign any_grant  = grant_right || grant_left;
	assign add_points = grant_right ? points_right : points_left;

	assign next_total = score_total + add_points;
	assign next_right = score_right + points_right;
	assign next_left  = score_left + points_left;

	//////////////////////////////
	// score registers
	//////////////////////////////

	// total survives a new round
	always_ff @(posedge Clk) begin
		if (reset) begin
			score_total <= '0;
		end else if (!new_round && any_grant) begin
			score_total <= next_total;
		end
	end

	// side scores only move in two-player mode
	always_ff @(posedge Clk) begin
		if (reset || new_round) begin
			score_right <= '0;
		end else if (grant_right && two_player) begin
			score_right <= next_right;
		end
	end

	always_ff @(posedge Clk) begin
		if (reset || new_round) begin
			score_left <= '0;
		end else if (grant_left && two_player) begin
			score_left <= next_left;
		end
	end

	//////////////////////////////
	// end of time verdict
	//////////////////////////////

	// compares the total held before this edge
	always_ff @(posedge Clk) begin
		if (reset) begin
			show_fail <= 1'b0;
		end else begin
			show_fail <= time_end && (score_total < target_score);
		end
	end

endmodule

// File: target_ledger.sv
module target_ledger (
	input  logic                  Clk,
	input  logic                  reset,
	input  logic                  clear,
	input  score_pkg::catch_vec_t catches,
	input  logic                  grant,
	output logic                  hit,
	output score_pkg::score_t     points
);

	// targets already scored this round
	score_pkg::catch_vec_t scored;

	// caught but not yet counted
	score_pkg::catch_vec_t pending;

	// lowest pending target
	logic [score_pkg::TARGET_IDX_W-1:0] sel_idx;

	//////////////////////////////
	// pending target selection
	//////////////////////////////

	assign pending = catches & ~scored;

	assign hit = |pending;

	// walk downward so the lowest index is the last one kept
	always_comb begin
		sel_idx = '0;
		for (int i = score_pkg::NUM_TARGETS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				sel_idx = score_pkg::TARGET_IDX_W'(i);
			end
		end
	end

	// table lookup of the selected target
	always_comb begin
		points = '0;
		for (int i = 0; i < score_pkg::NUM_TARGETS; i++) begin
			if (sel_idx == score_pkg::TARGET_IDX_W'(i)) begin
				points = score_pkg::TARGET_POINTS[i];
			end
		end
	end

	//////////////////////////////
	// scored flags
	//////////////////////////////

	// clear wins over a grant in the same cycle
	always_ff @(posedge Clk) begin
		if (reset || clear) begin
			scored <= '0;
		end else if (grant && hit) begin
			scored[sel_idx] <= 1'b1;
		end
	end

endmodule

// File: tb_catch_score.sv
module tb_catch_score;

	localparam int CLK_PERIOD     = 40;
	localparam int RESET_CYCLES   = 5;
	localparam int DRIVE_DELAY    = 2;
	localparam int TIMEOUT_CYCLES = 2000;

	logic                  Clk = 1'b0;
	logic                  reset;
	score_pkg::catch_vec_t catch_right;
	score_pkg::catch_vec_t catch_left;
	logic                  new_round;
	logic                  two_player;
	logic                  time_end;
	score_pkg::score_t     target_score;
	score_pkg::digits_t    total_digits;
	score_pkg::digits_t    left_digits;
	score_pkg::digits_t    right_digits;
	logic                  show_fail;

	integer seed;
	int     cycle_count = 0;

	// reference model state
	score_pkg::score_t exp_total;
	score_pkg::score_t exp_left;
	score_pkg::score_t exp_right;
	logic              scored_right [score_pkg::NUM_TARGETS];
	logic              scored_left [score_pkg::NUM_TARGETS];

	catch_score_top i_catch_score_top (
		.Clk          (Clk),
		.reset        (reset),
		.catch_right  (catch_right),
		.catch_left   (catch_left),
		.new_round    (new_round),
		.two_player   (two_player),
		.time_end     (time_end),
		.target_score (target_score),
		.total_digits (total_digits),
		.left_digits  (left_digits),
		.right_digits (right_digits),
		.show_fail    (show_fail)
	);

	always begin
		#(CLK_PERIOD / 2) Clk = ~Clk;
	end

	always @(posedge Clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the simulation ran %0d cycles without finishing", cycle_count);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic next_cycle();
		@(posedge Clk);
		#DRIVE_DELAY;
	endtask

	// score modulo 100000 split into digits with the ones first
	function automatic score_pkg::digits_t to_decimal(input score_pkg::score_t value);
		score_pkg::digits_t result;
		int rest;
		rest = value % 100000;
		for (int i = 0; i < score_pkg::NUM_DIGITS; i++) begin
			result[i] = score_pkg::DIGIT_W'(rest % 10);
			rest = rest / 10;
		end
		return result;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] time %0t: %s expected %h, actual %h", $time, name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_display();
		check_value("total_digits", 32'(to_decimal(exp_total)), 32'(total_digits));
		check_value("left_digits", 32'(to_decimal(exp_left)), 32'(left_digits));
		check_value("right_digits", 32'(to_decimal(exp_right)), 32'(right_digits));
	endtask

	// one target counted at most once per round
	task automatic model_catch(input bit right_side, input int idx);
		score_pkg::score_t pts;
		pts = score_pkg::TARGET_POINTS[idx];
		if (right_side && !scored_right[idx]) begin
			scored_right[idx] = 1'b1;
			exp_total = exp_total + pts;
			if (two_player) begin
				exp_right = exp_right + pts;
			end
		end else if (!right_side && !scored_left[idx]) begin
			scored_left[idx] = 1'b1;
			exp_total = exp_total + pts;
			if (two_player) begin
				exp_left = exp_left + pts;
			end
		end
	endtask

	// catch held for 2 cycles and digits checked 3 cycles after driving
	task automatic catch_target(input bit right_side, input int idx);
		if (right_side) begin
			catch_right[idx] = 1'b1;
		end else begin
			catch_left[idx] = 1'b1;
		end
		next_cycle();
		next_cycle();
		catch_right = '0;
		catch_left  = '0;
		next_cycle();
		model_catch(right_side, idx);
		check_display();
	endtask

	task automatic start_round();
		new_round = 1'b1;
		next_cycle();
		new_round = 1'b0;
		exp_left  = '0;
		exp_right = '0;
		for (int i = 0; i < score_pkg::NUM_TARGETS; i++) begin
			scored_right[i] = 1'b0;
			scored_left[i]  = 1'b0;
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_reset();
		check_display();
		check_value("show_fail", 32'(1'b0), 32'(show_fail));
	endtask

	task automatic test_two_player();
		int order [2*score_pkg::NUM_TARGETS];
		int pick;
		int tmp;
		two_player = 1'b1;
		for (int i = 0; i < 2 * score_pkg::NUM_TARGETS; i++) begin
			order[i] = i;
		end
		for (int i = 2 * score_pkg::NUM_TARGETS - 1; i > 0; i--) begin
			pick = $unsigned($random(seed)) % (i + 1);
			tmp = order[i];
			order[i] = order[pick];
			order[pick] = tmp;
		end
		for (int i = 0; i < 2 * score_pkg::NUM_TARGETS; i++) begin
			catch_target(order[i] >= score_pkg::NUM_TARGETS, order[i] % score_pkg::NUM_TARGETS);
		end
		// repeats in the same round must not count
		repeat (4) begin
			pick = $unsigned($random(seed)) % (2 * score_pkg::NUM_TARGETS);
			catch_target(pick >= score_pkg::NUM_TARGETS, pick % score_pkg::NUM_TARGETS);
		end
	endtask

	task automatic test_single_player();
		start_round();
		two_player = 1'b1;
		for (int i = 0; i < 3; i++) begin
			catch_target(1'b1, i);
			catch_target(1'b0, i);
		end
		// side scores now frozen
		two_player = 1'b0;
		for (int i = 3; i < score_pkg::NUM_TARGETS; i++) begin
			catch_target(1'b1, i);
			catch_target(1'b0, i);
		end
	endtask

	task automatic test_held_together();
		score_pkg::catch_vec_t right_set;
		score_pkg::catch_vec_t left_set;
		start_round();
		two_player  = 1'b1;
		right_set   = 14'b10_0001_0001_0001;
		left_set    = 14'b00_1010_0000_0101;
		catch_right = right_set;
		catch_left  = left_set;
		repeat (30) next_cycle();
		catch_right = '0;
		catch_left  = '0;
		repeat (3) next_cycle();
		for (int i = 0; i < score_pkg::NUM_TARGETS; i++) begin
			if (right_set[i]) begin
				model_catch(1'b1, i);
			end
			if (left_set[i]) begin
				model_catch(1'b0, i);
			end
		end
		check_display();
	endtask

	task automatic test_new_round();
		start_round();
		next_cycle();
		next_cycle();
		check_value("left_digits", 32'h0, 32'(left_digits));
		check_value("right_digits", 32'h0, 32'(right_digits));
		check_display();
		// targets from the last round score again
		catch_target(1'b1, 8);
		catch_target(1'b0, 9);
	endtask

	task automatic test_verdict();
		time_end     = 1'b1;
		target_score = exp_total + 1;
		next_cycle();
		check_value("show_fail", 32'(1'b1), 32'(show_fail));
		target_score = exp_total;
		next_cycle();
		check_value("show_fail", 32'(1'b0), 32'(show_fail));
		time_end     = 1'b0;
		target_score = exp_total + 1;
		next_cycle();
		check_value("show_fail", 32'(1'b0), 32'(show_fail));
		target_score = '1;
		next_cycle();
		check_value("show_fail", 32'(1'b0), 32'(show_fail));
	endtask

	initial begin
		seed         = 32'h1cdb_7ec8;
		reset        = 1'b1;
		catch_right  = '0;
		catch_left   = '0;
		new_round    = 1'b0;
		two_player   = 1'b0;
		time_end     = 1'b0;
		target_score = '0;
		exp_total    = '0;
		exp_left     = '0;
		exp_right    = '0;
		for (int i = 0; i < score_pkg::NUM_TARGETS; i++) begin
			scored_right[i] = 1'b0;
			scored_left[i]  = 1'b0;
		end
		repeat (RESET_CYCLES) @(posedge Clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		test_reset();
		test_two_player();
		test_single_player();
		test_held_together();
		test_new_round();
		test_verdict();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
